// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  // Datapath width of the front end
  localparam int unsigned XLEN = 32;

  // First address fetched after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Byte distance between consecutive instructions
  localparam int unsigned INST_BYTES = 4;

  // Instruction memory geometry
  localparam int unsigned IMEM_DEPTH = 64;
  localparam int unsigned IMEM_ADDR_BITS = 6;
  // Word index starts above the byte offset
  localparam int unsigned IMEM_ADDR_LSB = 2;

  // Program counter value
  typedef logic [XLEN-1:0] pc_t;

  // Raw instruction word
  typedef logic [31:0] inst_t;

  // Word index into instruction memory, PC bits 7 to 2
  typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t;

  // Source of the next PC
  typedef enum logic [1:0] {
    pc_sel_sequential = 2'd0,
    pc_sel_predicted  = 2'd1,
    pc_sel_redirect   = 2'd2
  } pc_sel_t;

endpackage

// ==== logic/bpred_pkg.sv ====
package bpred_pkg;

  // Direct-mapped BTB size
  localparam int unsigned BTB_ENTRIES = 16;

  // Index field sits right above the instruction byte offset
  localparam int unsigned BTB_INDEX_LSB = 2;
  localparam int unsigned BTB_INDEX_BITS = 4;

  // Tag covers every PC bit above the index
  localparam int unsigned BTB_TAG_LSB = 6;
  localparam int unsigned BTB_TAG_BITS = 26;

  // Entry index, PC bits 5 to 2
  typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;

  // Stored tag, PC bits 31 to 6
  typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

endpackage

// ==== logic/pc_stream_if.sv ====
`timescale 1ns/1ps

// Valid/ready stream of issued PCs between the PC stage and the fetch stage
interface pc_stream_if #(
  parameter int unsigned PC_W = 32
);

  // Item present on the stream
  logic valid;
  // Downstream can take the item this cycle
  logic ready;
  // Issued PC
  logic [PC_W-1:0] pc;
  // BTB hit on this PC
  logic pred_taken;
  // Item left the PC register on a redirect, so it is wrong-path
  logic redirect_pending;

  // Producer side
  modport issue (
    output valid,
    output pc,
    output pred_taken,
    output redirect_pending,
    input  ready
  );

  // Consumer side
  modport fetch (
    input  valid,
    input  pc,
    input  pred_taken,
    input  redirect_pending,
    output ready
  );

endinterface

// ==== logic/pc_select.sv ====
`timescale 1ns/1ps

module pc_select (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect_valid,
  input  fetch_pkg::pc_t    redirect_target,
  input  logic              btb_hit,
  input  fetch_pkg::pc_t    btb_target,
  input  logic              advance,
  output fetch_pkg::pc_sel_t pc_sel,
  output fetch_pkg::pc_t    target
);

  import fetch_pkg::*;

  // Redirect that came in while the PC register was stalled
  logic held_valid;
  pc_t  held_target;

  // Control part of the held redirect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
    end else if (advance) begin
      // Any advance consumes whatever redirect is selected now
      held_valid <= 1'b0;
    end else if (redirect_valid) begin
      held_valid <= 1'b1;
    end
  end

  // A newer pulse simply overwrites the held target
  always_ff @(posedge clk) begin
    if (redirect_valid && !advance) begin
      held_target <= redirect_target;
    end
  end

  // Priority: live redirect, held redirect, BTB hit, then fall through
  always_comb begin
    pc_sel = pc_sel_sequential;
    // Target is ignored on the sequential path
    target = btb_target;
    if (redirect_valid) begin
      pc_sel = pc_sel_redirect;
      target = redirect_target;
    end else if (held_valid) begin
      pc_sel = pc_sel_redirect;
      target = held_target;
    end else if (btb_hit) begin
      pc_sel = pc_sel_predicted;
      target = btb_target;
    end
  end

endmodule

// ==== logic/pc_stage.sv ====
`timescale 1ns/1ps

module pc_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::pc_sel_t pc_sel,
  input  fetch_pkg::pc_t     target,
  output fetch_pkg::pc_t     pc,
  output logic               advance,
  input  logic               btb_hit,
  pc_stream_if.issue         issue
);

  import fetch_pkg::*;

  // Next PC from the selected source
  pc_t pc_next;

  // Stream registers behind the modport
  logic issue_valid;
  logic issue_pending;
  logic issue_pred;
  pc_t  issue_pc;

  // The stream slot is free or is being drained this cycle
  assign advance = !issue_valid || issue.ready;

  // Next-PC mux
  always_comb begin
    case (pc_sel)
      pc_sel_redirect:   pc_next = target;
      pc_sel_predicted:  pc_next = target;
      pc_sel_sequential: pc_next = pc + pc_t'(INST_BYTES);
      default:           pc_next = pc + pc_t'(INST_BYTES);
    endcase
  end

  // PC register
  // Only moves on a cycle where its current value is issued
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (advance) begin
      pc <= pc_next;
    end
  end

  // Stream control bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid   <= 1'b0;
      issue_pending <= 1'b0;
    end else if (advance) begin
      // Always a PC to offer once the first one is out
      issue_valid <= 1'b1;
      // PC leaving on a redirect was fetched down the old path
      issue_pending <= (pc_sel == pc_sel_redirect);
    end
  end

  // Stream payload
  // BTB lookup runs on pc, so the hit lines up with the issued PC
  always_ff @(posedge clk) begin
    if (advance) begin
      issue_pc   <= pc;
      issue_pred <= btb_hit;
    end
  end

  assign issue.valid            = issue_valid;
  assign issue.pc               = issue_pc;
  assign issue.pred_taken       = issue_pred;
  assign issue.redirect_pending = issue_pending;

endmodule

// ==== logic/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
  input  logic           clk,
  input  logic           rst_n,
  input  fetch_pkg::pc_t lookup_pc,
  output logic           hit,
  output fetch_pkg::pc_t hit_target,
  input  logic           wr_en,
  input  fetch_pkg::pc_t wr_pc,
  input  fetch_pkg::pc_t wr_target
);

  import fetch_pkg::*;
  import bpred_pkg::*;

  // One valid bit per entry
  logic [BTB_ENTRIES-1:0] entry_valid;

  // Tag and target storage
  btb_tag_t entry_tag    [BTB_ENTRIES];
  pc_t      entry_target [BTB_ENTRIES];

  // Lookup fields
  btb_index_t lookup_idx;
  btb_tag_t   lookup_tag;

  // Update fields
  btb_index_t wr_idx;
  btb_tag_t   wr_tag;

  assign lookup_idx = lookup_pc[BTB_INDEX_LSB +: BTB_INDEX_BITS];
  assign lookup_tag = lookup_pc[BTB_TAG_LSB +: BTB_TAG_BITS];

  assign wr_idx = wr_pc[BTB_INDEX_LSB +: BTB_INDEX_BITS];
  assign wr_tag = wr_pc[BTB_TAG_LSB +: BTB_TAG_BITS];

  // Valid bits start empty
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
    end else if (wr_en) begin
      entry_valid[wr_idx] <= 1'b1;
    end
  end

  // Write replaces whatever lived in the slot
  always_ff @(posedge clk) begin
    if (wr_en) begin
      entry_tag[wr_idx]    <= wr_tag;
      entry_target[wr_idx] <= wr_target;
    end
  end

  // Combinational lookup
  // Updates show up one edge after the write
  always_comb begin
    hit        = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    hit_target = entry_target[lookup_idx];
  end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  pc_stream_if.fetch      fetch,
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            imem_wr_en,
  input  fetch_pkg::imem_addr_t imem_wr_addr,
  input  fetch_pkg::inst_t imem_wr_data,
  output logic            inst_valid,
  input  logic            inst_ready,
  output fetch_pkg::pc_t  inst_pc,
  output fetch_pkg::inst_t inst_word,
  output logic            inst_pred_taken
);

  import fetch_pkg::*;

  // Instruction memory
  inst_t imem [IMEM_DEPTH];

  // Read side
  imem_addr_t rd_addr;
  inst_t      rd_word;

  // Handshake terms
  logic accept;
  logic load;

  // Write port for loading programs
  always_ff @(posedge clk) begin
    if (imem_wr_en) begin
      imem[imem_wr_addr] <= imem_wr_data;
    end
  end

  // Asynchronous read on the word index of the stream PC
  assign rd_addr = fetch.pc[IMEM_ADDR_LSB +: IMEM_ADDR_BITS];
  assign rd_word = imem[rd_addr];

  // Room when empty, being drained, or about to be flushed
  // On flush the stream item is taken and thrown away
  assign fetch.ready = !inst_valid || inst_ready || flush;

  assign accept = fetch.valid && fetch.ready;

  // Wrong-path items and anything caught by the flush are dropped
  assign load = accept && !fetch.redirect_pending && !flush;

  // Output valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst_valid <= 1'b0;
    end else if (flush) begin
      inst_valid <= 1'b0;
    end else if (load) begin
      inst_valid <= 1'b1;
    end else if (inst_ready) begin
      // Consumed with nothing behind it
      inst_valid <= 1'b0;
    end
  end

  // Output payload
  // Holds while the decode side stalls since load needs ready
  always_ff @(posedge clk) begin
    if (load) begin
      inst_pc         <= fetch.pc;
      inst_word       <= rd_word;
      inst_pred_taken <= fetch.pred_taken;
    end
  end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  redirect_valid,
  input  fetch_pkg::pc_t        redirect_target,
  input  logic                  btb_wr_en,
  input  fetch_pkg::pc_t        btb_wr_pc,
  input  fetch_pkg::pc_t        btb_wr_target,
  input  logic                  imem_wr_en,
  input  fetch_pkg::imem_addr_t imem_wr_addr,
  input  fetch_pkg::inst_t      imem_wr_data,
  output logic                  inst_valid,
  input  logic                  inst_ready,
  output fetch_pkg::pc_t        inst_pc,
  output fetch_pkg::inst_t      inst_word,
  output logic                  inst_pred_taken
);

  import fetch_pkg::*;

  // Selection result into the PC stage
  pc_sel_t pc_sel;
  pc_t     sel_target;

  // Current PC and its BTB lookup
  pc_t  cur_pc;
  logic btb_hit;
  pc_t  btb_target;

  // PC register moves this cycle
  logic advance;

  // PC stream between the PC stage and the fetch stage
  pc_stream_if #(.PC_W(XLEN)) stream_if ();

  pc_select u_pc_select (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .btb_hit         (btb_hit),
    .btb_target      (btb_target),
    .advance         (advance),
    .pc_sel          (pc_sel),
    .target          (sel_target)
  );

  pc_stage u_pc_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc_sel  (pc_sel),
    .target  (sel_target),
    .pc      (cur_pc),
    .advance (advance),
    .btb_hit (btb_hit),
    .issue   (stream_if.issue)
  );

  // Lookup runs on the PC register itself
  branch_target_buffer u_btb (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup_pc  (cur_pc),
    .hit        (btb_hit),
    .hit_target (btb_target),
    .wr_en      (btb_wr_en),
    .wr_pc      (btb_wr_pc),
    .wr_target  (btb_wr_target)
  );

  // Redirect pulse doubles as the fetch flush
  fetch_stage u_fetch_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch           (stream_if.fetch),
    .flush           (redirect_valid),
    .imem_wr_en      (imem_wr_en),
    .imem_wr_addr    (imem_wr_addr),
    .imem_wr_data    (imem_wr_data),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .inst_pc         (inst_pc),
    .inst_word       (inst_word),
    .inst_pred_taken (inst_pred_taken)
  );

endmodule

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;
  import bpred_pkg::*;

  localparam logic [31:0] SEED = 32'hadfd9cbb;

  // Planned accepted instructions over all tests
  localparam int TRANSFERS = 40 + 6 * 8 + 4 + 30 + 60 + 5 * 5;
  // Reset, memory fill, BTB setup, stalls and refill after redirects
  localparam int SETUP_CYCLES = 200;
  localparam int CYCLE_LIMIT = 2 * TRANSFERS + SETUP_CYCLES;

  // Expected response for one PC
  typedef struct packed {
    inst_t word;
    logic  pred;
    pc_t   next_pc;
  } ref_t;

  logic       clk;
  logic       rst_n;
  logic       redirect_valid;
  pc_t        redirect_target;
  logic       btb_wr_en;
  pc_t        btb_wr_pc;
  pc_t        btb_wr_target;
  logic       imem_wr_en;
  imem_addr_t imem_wr_addr;
  inst_t      imem_wr_data;
  logic       inst_valid;
  logic       inst_ready;
  pc_t        inst_pc;
  inst_t      inst_word;
  logic       inst_pred_taken;

  // Model state
  inst_t    model_mem [IMEM_DEPTH];
  logic     model_btb_valid [BTB_ENTRIES];
  btb_tag_t model_btb_tag [BTB_ENTRIES];
  pc_t      model_btb_target [BTB_ENTRIES];
  pc_t      exp_pc;
  ref_t     exp;

  // Stall stability tracking
  logic  prev_stall;
  pc_t   prev_pc;
  inst_t prev_word;

  // Counters
  int accepted;
  int checks;
  int errors;
  int pred_seen;
  int stall_checks;
  int cycles;
  int test_start;
  int mark;
  int goal;
  int n;
  int k;
  logic [31:0] seed_val;

  fetch_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .btb_wr_en       (btb_wr_en),
    .btb_wr_pc       (btb_wr_pc),
    .btb_wr_target   (btb_wr_target),
    .imem_wr_en      (imem_wr_en),
    .imem_wr_addr    (imem_wr_addr),
    .imem_wr_data    (imem_wr_data),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .inst_pc         (inst_pc),
    .inst_word       (inst_word),
    .inst_pred_taken (inst_pred_taken)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Word, predicted flag and following PC for a given PC
  function automatic ref_t ref_step(input pc_t pc);
    ref_t       r;
    logic [3:0] idx;
    idx       = pc[5:2];
    r.word    = model_mem[pc[7:2]];
    r.pred    = model_btb_valid[idx] && (model_btb_tag[idx] == pc[31:6]);
    // Taken prediction jumps to the stored target
    r.next_pc = r.pred ? model_btb_target[idx] : pc + 32'd4;
    return r;
  endfunction

  // Compare process sampling everything on the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc     = RESET_PC;
      prev_stall = 1'b0;
      for (k = 0; k < BTB_ENTRIES; k++) begin
        model_btb_valid[k] = 1'b0;
      end
    end else begin
      // Held output must not move under back-pressure
      // A word loaded before the memory fill is still unknown
      if (prev_stall) begin
        stall_checks = stall_checks + 1;
        checks = checks + 3;
        assert (inst_valid) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_valid expected 1 got %b", $time, inst_valid);
        end
        assert (inst_pc === prev_pc) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_pc expected %h got %h", $time, prev_pc, inst_pc);
        end
        assert (inst_word === prev_word) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_word expected %h got %h", $time, prev_word, inst_word);
        end
      end
      if (inst_valid && inst_ready) begin
        exp = ref_step(exp_pc);
        checks = checks + 3;
        assert (inst_pc == exp_pc) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_pc expected %h got %h", $time, exp_pc, inst_pc);
        end
        assert (inst_word == exp.word) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_word expected %h got %h", $time, exp.word, inst_word);
        end
        assert (inst_pred_taken == exp.pred) else begin
          errors = errors + 1;
          $display("[FAIL] %0t inst_pred_taken expected %b got %b", $time, exp.pred,
                   inst_pred_taken);
        end
        if (inst_pred_taken) pred_seen = pred_seen + 1;
        // Keep following the model path even after a mismatch
        exp_pc = exp.next_pc;
        accepted <= accepted + 1;
      end
      // Redirect wins over whatever the model would have fetched next
      if (redirect_valid) exp_pc = redirect_target;
      if (imem_wr_en) model_mem[imem_wr_addr] = imem_wr_data;
      if (btb_wr_en) begin
        model_btb_valid[btb_wr_pc[5:2]]  = 1'b1;
        model_btb_tag[btb_wr_pc[5:2]]    = btb_wr_pc[31:6];
        model_btb_target[btb_wr_pc[5:2]] = btb_wr_target;
      end
      // A flush may legally clear a stalled output
      prev_stall = inst_valid && !inst_ready && !redirect_valid;
      prev_pc    = inst_pc;
      prev_word  = inst_word;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d instructions accepted", cycles, accepted);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Random words into every memory location
  task automatic fill_imem();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(posedge clk);
      imem_wr_en   <= 1'b1;
      imem_wr_addr <= imem_addr_t'(i);
      imem_wr_data <= $urandom;
    end
    @(posedge clk);
    imem_wr_en <= 1'b0;
  endtask

  // One-cycle redirect that sets ready as asked when the pulse ends
  task automatic pulse_redirect(input pc_t target, input logic ready_after);
    @(posedge clk);
    redirect_valid  <= 1'b1;
    redirect_target <= target;
    @(posedge clk);
    redirect_valid <= 1'b0;
    inst_ready     <= ready_after;
  endtask

  task automatic write_btb(input pc_t pc, input pc_t target);
    @(posedge clk);
    btb_wr_en     <= 1'b1;
    btb_wr_pc     <= pc;
    btb_wr_target <= target;
  endtask

  task automatic wait_accepts(input int count);
    int target_count;
    target_count = accepted + count;
    while (accepted < target_count) @(posedge clk);
  endtask

  // Per-test summary line
  task automatic report_test(input string name, input int err_before);
    @(negedge clk);
    if (errors == err_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    seed_val        = $urandom(SEED);
    rst_n           = 1'b0;
    redirect_valid  = 1'b0;
    redirect_target = '0;
    btb_wr_en       = 1'b0;
    btb_wr_pc       = '0;
    btb_wr_target   = '0;
    imem_wr_en      = 1'b0;
    imem_wr_addr    = '0;
    imem_wr_data    = '0;
    inst_ready      = 1'b0;
    accepted        = 0;
    checks          = 0;
    errors          = 0;
    pred_seen       = 0;
    stall_checks    = 0;
    cycles          = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Test 1 loads the program under stall and restarts at the reset address
    test_start = errors;
    fill_imem();
    pulse_redirect(RESET_PC, 1'b1);
    wait_accepts(40);
    report_test("sequential fetch", test_start);

    // Test 2 redirects while streaming
    test_start = errors;
    for (n = 0; n < 6; n++) begin
      wait_accepts(2 + $urandom % 7);
      pulse_redirect($urandom & 32'hffff_fffc, 1'b1);
    end
    wait_accepts(4);
    report_test("redirect", test_start);

    // Test 3 loops from 0x40 through 0x48 and 0x8c to 0x94 and back to 0x40
    test_start = errors;
    mark = pred_seen;
    @(posedge clk);
    inst_ready <= 1'b0;
    repeat (2) @(posedge clk);
    write_btb(32'h0000_0048, 32'h0000_008c);
    write_btb(32'h0000_0094, 32'h0000_0040);
    // Same index as 0x44 with a foreign tag that must never hit
    write_btb(32'h0000_1044, 32'h0000_0300);
    @(posedge clk);
    btb_wr_en <= 1'b0;
    pulse_redirect(32'h0000_0040, 1'b1);
    wait_accepts(30);
    assert (pred_seen > mark) else begin
      errors = errors + 1;
      $display("No predicted-taken instruction was seen in the BTB test");
    end
    report_test("btb prediction", test_start);

    // Test 4 applies random back-pressure
    test_start = errors;
    mark = stall_checks;
    goal = accepted + 60;
    while (accepted < goal) begin
      @(posedge clk);
      inst_ready <= ($urandom % 2) == 1;
    end
    @(posedge clk);
    inst_ready <= 1'b1;
    assert (stall_checks > mark) else begin
      errors = errors + 1;
      $display("Back-pressure test never held a stalled output");
    end
    report_test("back-pressure", test_start);

    // Test 5 redirects while the output is stalled
    test_start = errors;
    for (n = 0; n < 5; n++) begin
      @(posedge clk);
      inst_ready <= 1'b0;
      repeat (3) @(posedge clk);
      pulse_redirect($urandom & 32'hffff_fffc, 1'b0);
      repeat (2) @(posedge clk);
      inst_ready <= 1'b1;
      wait_accepts(5);
    end
    report_test("redirect under stall", test_start);

    @(negedge clk);
    $display("accepted %0d, checks %0d, errors %0d", accepted, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/fetch_pkg.sv
logic/bpred_pkg.sv
logic/pc_stream_if.sv
logic/pc_select.sv
logic/pc_stage.sv
logic/branch_target_buffer.sv
logic/fetch_stage.sv
logic/fetch_top.sv
test/fetch_tb.sv
